/* hw/engine_pkg.sv */
package engine_pkg;

    // audio sample format
    localparam int sample_width = 16;

    typedef logic signed [sample_width-1:0] sample_t;

    // gain coefficients are Q2.14
    typedef logic signed [15:0] coef_t;

    localparam int coef_frac_bits = 14;

    localparam coef_t coef_unity = coef_t'(1 << coef_frac_bits);

    typedef enum logic [1:0] {
        st_ready,
        st_processing_wait,
        st_processing,
        st_mixing
    } engine_state_t;

endpackage

/* hw/command_pkg.sv */
package command_pkg;

    typedef logic [7:0] cmd_byte_t;

    // first byte of every command
    // set_coef is followed by index, data hi, data lo
    typedef enum logic [7:0] {
        op_set_coef     = 8'd1,
        op_swap         = 8'd2,
        op_clear_shadow = 8'd3
    } opcode_t;

    // which byte of a command the decoder expects next
    typedef enum logic [1:0] {
        dec_opcode,
        dec_index,
        dec_data_hi,
        dec_data_lo
    } decode_state_t;

endpackage

/* hw/command_fifo.sv */
`timescale 1ns/1ps

module command_fifo import command_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cmd_byte_t                   wr_data,
    input  logic                        wr_en,
    input  logic                        pop,
    output cmd_byte_t                   rd_data,
    output logic                        nonempty,
    output logic [$clog2(fifo_depth):0] count
);

    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

    cmd_byte_t            mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic                 do_write;
    logic                 do_read;

    assign nonempty = (count != '0);
    assign do_write = wr_en && (count != ($clog2(fifo_depth) + 1)'(fifo_depth));
    assign do_read  = pop && nonempty;
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hw/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder import engine_pkg::*, command_pkg::*; #(
    parameter int n_blocks = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  cmd_byte_t cmd_byte,
    input  logic      nonempty,
    output logic      pop,
    output logic      coef_write,
    output logic [((n_blocks > 1) ? $clog2(n_blocks) : 1)-1:0] coef_index,
    output coef_t     coef_value,
    output logic      swap_req,
    output logic      clear_shadow,
    output logic      invalid
);

    localparam int idx_width = (n_blocks > 1) ? $clog2(n_blocks) : 1;

    decode_state_t state;
    cmd_byte_t     index_q;
    cmd_byte_t     data_hi_q;

    // one idle cycle after an error keeps invalid a single pulse
    assign pop = nonempty && !invalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= dec_opcode;
            coef_write   <= 1'b0;
            swap_req     <= 1'b0;
            clear_shadow <= 1'b0;
            invalid      <= 1'b0;
        end else begin
            coef_write   <= 1'b0;
            swap_req     <= 1'b0;
            clear_shadow <= 1'b0;
            invalid      <= 1'b0;
            if (pop) begin
                case (state)
                    dec_opcode: begin
                        case (cmd_byte)
                            op_set_coef:     state <= dec_index;
                            op_swap:         swap_req <= 1'b1;
                            op_clear_shadow: clear_shadow <= 1'b1;
                            default:         invalid <= 1'b1;
                        endcase
                    end
                    dec_index:   state <= dec_data_hi;
                    dec_data_hi: state <= dec_data_lo;
                    dec_data_lo: begin
                        // bad index still consumes all four bytes
                        if (int'(index_q) < n_blocks) begin
                            coef_write <= 1'b1;
                        end else begin
                            invalid <= 1'b1;
                        end
                        state <= dec_opcode;
                    end
                    default: state <= dec_opcode;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            case (state)
                dec_index:   index_q <= cmd_byte;
                dec_data_hi: data_hi_q <= cmd_byte;
                dec_data_lo: begin
                    coef_index <= index_q[idx_width-1:0];
                    coef_value <= {data_hi_q, cmd_byte};
                end
                default: ;
            endcase
        end
    end

endmodule

/* hw/block_pipeline.sv */
`timescale 1ns/1ps

module block_pipeline import engine_pkg::*; #(
    parameter int n_blocks = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  sample_t sample_in,
    input  logic    coef_write,
    input  logic    clear,
    input  logic [((n_blocks > 1) ? $clog2(n_blocks) : 1)-1:0] coef_index,
    input  coef_t   coef_value,
    output sample_t result,
    output logic    done
);

    localparam int idx_width  = (n_blocks > 1) ? $clog2(n_blocks) : 1;
    localparam int prod_width = sample_width + $bits(coef_t);
    localparam int sat_hi     = 2 ** (sample_width - 1) - 1;
    localparam int sat_lo     = -(2 ** (sample_width - 1));

    coef_t                coef [n_blocks];
    logic [idx_width-1:0] blk;
    logic                 busy;
    sample_t              acc;

    // one gain block: Q2.14 multiply, then clip to sample range
    function automatic sample_t scale(input sample_t s, input coef_t c);
        logic signed [prod_width-1:0] prod;
        prod = s * c;
        prod = prod >>> coef_frac_bits;
        if (prod > sat_hi) begin
            return sample_t'(sat_hi);
        end
        if (prod < sat_lo) begin
            return sample_t'(sat_lo);
        end
        return sample_t'(prod);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef <= '{default: coef_unity};
        end else if (clear) begin
            coef <= '{default: coef_unity};
        end else if (coef_write) begin
            coef[coef_index] <= coef_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            blk  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            blk  <= '0;
        end else if (busy) begin
            if (blk == idx_width'(n_blocks - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
                blk  <= '0;
            end else begin
                blk <= blk + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= sample_in;
        end else if (busy) begin
            acc <= scale(acc, coef[blk]);
        end
    end

    assign result = acc;

endmodule

/* hw/pipeline_switch.sv */
`timescale 1ns/1ps

module pipeline_switch import engine_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    swap_req,
    input  logic    boundary,
    input  logic    start,
    input  logic    coef_write,
    input  logic    clear_shadow,
    output logic    coef_write_a,
    output logic    coef_write_b,
    output logic    clear_a,
    output logic    clear_b,
    input  sample_t result_a,
    input  sample_t result_b,
    output sample_t active_sample
);

    // low while pipeline a is active
    logic active;
    logic pending;
    logic apply;

    // swap only between samples
    assign apply = pending && boundary && !start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            pending <= 1'b0;
        end else if (apply) begin
            active  <= ~active;
            pending <= swap_req;
        end else if (swap_req) begin
            pending <= 1'b1;
        end
    end

    assign coef_write_a  = coef_write && active;
    assign coef_write_b  = coef_write && !active;
    assign clear_a       = clear_shadow && active;
    assign clear_b       = clear_shadow && !active;
    assign active_sample = active ? result_b : result_a;

endmodule

/* hw/engine_sequencer.sv */
`timescale 1ns/1ps

module engine_sequencer import engine_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_ready,
    input  sample_t in_sample,
    input  logic    done_a,
    input  logic    done_b,
    input  sample_t active_sample,
    output logic    start,
    output sample_t sample_in,
    output logic    boundary,
    output sample_t out_sample,
    output logic    ready
);

    engine_state_t state;
    logic          accept;

    assign accept   = (state == st_ready) && sample_ready;
    assign boundary = (state == st_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_ready;
            start      <= 1'b0;
            ready      <= 1'b1;
            out_sample <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                st_ready: begin
                    if (sample_ready) begin
                        start <= 1'b1;
                        ready <= 1'b0;
                        state <= st_processing_wait;
                    end
                end
                // done flags still show the previous sample here
                st_processing_wait: state <= st_processing;
                st_processing: begin
                    if (done_a && done_b) begin
                        state <= st_mixing;
                    end
                end
                st_mixing: begin
                    out_sample <= active_sample;
                    ready      <= 1'b1;
                    state      <= st_ready;
                end
                default: state <= st_ready;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sample_in <= in_sample;
        end
    end

endmodule

/* hw/dsp_engine.sv */
`timescale 1ns/1ps

module dsp_engine import engine_pkg::*, command_pkg::*; #(
    parameter int n_blocks   = 4,
    parameter int fifo_depth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  sample_t                     in_sample,
    input  logic                        sample_ready,
    output sample_t                     out_sample,
    output logic                        ready,
    input  cmd_byte_t                   command_in,
    input  logic                        command_in_ready,
    output logic                        invalid_command,
    output logic [$clog2(fifo_depth):0] fifo_count
);

    localparam int idx_width = (n_blocks > 1) ? $clog2(n_blocks) : 1;

    cmd_byte_t            cmd_byte;
    logic                 fifo_nonempty;
    logic                 pop;
    logic                 coef_write;
    logic [idx_width-1:0] coef_index;
    coef_t                coef_value;
    logic                 swap_req;
    logic                 clear_shadow;
    logic                 coef_write_a;
    logic                 coef_write_b;
    logic                 clear_a;
    logic                 clear_b;
    logic                 start;
    sample_t              sample_in;
    logic                 boundary;
    logic                 done_a;
    logic                 done_b;
    sample_t              result_a;
    sample_t              result_b;
    sample_t              active_sample;

    command_fifo #(.fifo_depth(fifo_depth)) u_command_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (command_in),
        .wr_en    (command_in_ready),
        .pop      (pop),
        .rd_data  (cmd_byte),
        .nonempty (fifo_nonempty),
        .count    (fifo_count)
    );

    command_decoder #(.n_blocks(n_blocks)) u_command_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_byte     (cmd_byte),
        .nonempty     (fifo_nonempty),
        .pop          (pop),
        .coef_write   (coef_write),
        .coef_index   (coef_index),
        .coef_value   (coef_value),
        .swap_req     (swap_req),
        .clear_shadow (clear_shadow),
        .invalid      (invalid_command)
    );

    block_pipeline #(.n_blocks(n_blocks)) u_pipe_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .sample_in  (sample_in),
        .coef_write (coef_write_a),
        .clear      (clear_a),
        .coef_index (coef_index),
        .coef_value (coef_value),
        .result     (result_a),
        .done       (done_a)
    );

    block_pipeline #(.n_blocks(n_blocks)) u_pipe_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .sample_in  (sample_in),
        .coef_write (coef_write_b),
        .clear      (clear_b),
        .coef_index (coef_index),
        .coef_value (coef_value),
        .result     (result_b),
        .done       (done_b)
    );

    pipeline_switch u_pipeline_switch (
        .clk           (clk),
        .rst_n         (rst_n),
        .swap_req      (swap_req),
        .boundary      (boundary),
        .start         (start),
        .coef_write    (coef_write),
        .clear_shadow  (clear_shadow),
        .coef_write_a  (coef_write_a),
        .coef_write_b  (coef_write_b),
        .clear_a       (clear_a),
        .clear_b       (clear_b),
        .result_a      (result_a),
        .result_b      (result_b),
        .active_sample (active_sample)
    );

    engine_sequencer u_engine_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_ready  (sample_ready),
        .in_sample     (in_sample),
        .done_a        (done_a),
        .done_b        (done_b),
        .active_sample (active_sample),
        .start         (start),
        .sample_in     (sample_in),
        .boundary      (boundary),
        .out_sample    (out_sample),
        .ready         (ready)
    );

endmodule

/* testbench/dsp_engine_assert.sv */
`timescale 1ns/1ps

module dsp_engine_assert #(
    parameter int n_blocks   = 4,
    parameter int fifo_depth = 16
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        sample_ready,
    input logic                        ready,
    input logic                        invalid_command,
    input logic [$clog2(fifo_depth):0] fifo_count
);

    int   fail_count = 0;
    logic accepted;

    // a strobe only counts in the ready state
    assign accepted = sample_ready && ready;

    ready_falls: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> !ready)
    else begin
        fail_count++;
        $error("ready did not fall after an accepted sample");
    end

    // latch, wait, n_blocks of processing, done detect, mixing
    ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> ##(n_blocks + 4) $rose(ready))
    else begin
        fail_count++;
        $error("ready did not rise n_blocks + 4 cycles after an accepted sample");
    end

    invalid_single: assert property (@(posedge clk) disable iff (!rst_n)
        invalid_command |=> !invalid_command)
    else begin
        fail_count++;
        $error("invalid_command stayed high for two cycles");
    end

    fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(fifo_count) <= fifo_depth)
    else begin
        fail_count++;
        $error("fifo_count is above the FIFO depth");
    end

endmodule

bind dsp_engine dsp_engine_assert #(
    .n_blocks   (n_blocks),
    .fifo_depth (fifo_depth)
) u_dsp_engine_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .sample_ready    (sample_ready),
    .ready           (ready),
    .invalid_command (invalid_command),
    .fifo_count      (fifo_count)
);

/* testbench/tb_dsp_engine.sv */
`timescale 1ns/1ps

module tb_dsp_engine import engine_pkg::*, command_pkg::*;;

    localparam int n_blocks   = 4;
    localparam int fifo_depth = 16;
    localparam int period     = 40;
    // about 60 samples at 12 cycles each, commands and a wide margin
    localparam int max_cycles = 4000;

    logic                        clk;
    logic                        rst_n;
    sample_t                     in_sample;
    logic                        sample_ready;
    sample_t                     out_sample;
    logic                        ready;
    cmd_byte_t                   command_in;
    logic                        command_in_ready;
    logic                        invalid_command;
    logic [$clog2(fifo_depth):0] fifo_count;

    // reference model: both coefficient banks and which one is active
    int coef_a [n_blocks];
    int coef_b [n_blocks];
    bit active_b;
    int value_errors;
    int protocol_errors;
    int max_count;
    int invalid_pulses;
    int pulses_before;
    int cycles;
    int i;

    dsp_engine #(.n_blocks(n_blocks), .fifo_depth(fifo_depth)) u_dsp_engine (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_sample        (in_sample),
        .sample_ready     (sample_ready),
        .out_sample       (out_sample),
        .ready            (ready),
        .command_in       (command_in),
        .command_in_ready (command_in_ready),
        .invalid_command  (invalid_command),
        .fifo_count       (fifo_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (int'(fifo_count) > max_count) begin
            max_count <= int'(fifo_count);
        end
    end

    always @(posedge clk) begin
        if (invalid_command) begin
            invalid_pulses <= invalid_pulses + 1;
        end
    end

    // Q2.14 gain chain with clipping, on the active bank
    function automatic int chain_model(input int s);
        int acc;
        int c;
        acc = s;
        for (int k = 0; k < n_blocks; k++) begin
            c = active_b ? coef_b[k] : coef_a[k];
            acc = (acc * c) >>> 14;
            if (acc > 32767) begin
                acc = 32767;
            end else if (acc < -32768) begin
                acc = -32768;
            end
        end
        return acc;
    endfunction

    function automatic int random_sample();
        return int'(sample_t'($urandom));
    endfunction

    task automatic push_byte(input cmd_byte_t b);
        command_in       = b;
        command_in_ready = 1'b1;
        @(negedge clk);
        command_in_ready = 1'b0;
    endtask

    task automatic wait_commands_done();
        while (fifo_count != '0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic set_coef(input int idx, input int value);
        push_byte(op_set_coef);
        push_byte(8'(idx));
        push_byte(8'(value >>> 8));
        push_byte(8'(value));
        wait_commands_done();
        if (idx < n_blocks) begin
            if (active_b) begin
                coef_a[idx] = value;
            end else begin
                coef_b[idx] = value;
            end
        end
    endtask

    task automatic swap_pipelines();
        push_byte(op_swap);
        wait_commands_done();
        active_b = !active_b;
    endtask

    task automatic clear_shadow_bank();
        push_byte(op_clear_shadow);
        wait_commands_done();
        for (int k = 0; k < n_blocks; k++) begin
            if (active_b) begin
                coef_a[k] = 16384;
            end else begin
                coef_b[k] = 16384;
            end
        end
    endtask

    // extra strobe lands while the engine is busy and must be ignored
    task automatic run_sample(input string name, input int value, input bit extra_strobe);
        int expected;
        expected     = chain_model(value);
        in_sample    = sample_t'(value);
        sample_ready = 1'b1;
        @(negedge clk);
        sample_ready = 1'b0;
        if (extra_strobe) begin
            @(negedge clk);
            in_sample    = ~in_sample;
            sample_ready = 1'b1;
            @(negedge clk);
            sample_ready = 1'b0;
        end
        while (!ready) begin
            @(negedge clk);
        end
        assert (int'(out_sample) == expected)
        else begin
            $display("error %s: expected %0d, actual %0d", name, expected, int'(out_sample));
            value_errors++;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h10d4450d));
        rst_n            = 1'b0;
        in_sample        = '0;
        sample_ready     = 1'b0;
        command_in       = '0;
        command_in_ready = 1'b0;
        value_errors     = 0;
        protocol_errors  = 0;
        max_count        = 0;
        invalid_pulses   = 0;
        pulses_before    = 0;
        active_b         = 1'b0;
        for (int k = 0; k < n_blocks; k++) begin
            coef_a[k] = 16384;
            coef_b[k] = 16384;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (i = 0; i < 10; i++) begin
            run_sample("reset_unity", random_sample(), 1'b0);
        end

        // near 2.0, 1.5, -0.5 and 1.0 on the shadow bank
        set_coef(0, 32767);
        set_coef(1, 24576);
        set_coef(2, -8192);
        set_coef(3, 16384);
        for (i = 0; i < 4; i++) begin
            run_sample("shadow_hidden", random_sample(), 1'b0);
        end
        swap_pipelines();
        run_sample("gain_clip_max", 32767, 1'b0);
        run_sample("gain_clip_min", -32768, 1'b0);
        for (i = 0; i < 12; i++) begin
            run_sample("gain_chain", random_sample(), 1'b0);
        end

        swap_pipelines();
        for (i = 0; i < 4; i++) begin
            run_sample("swap_back", random_sample(), 1'b0);
        end
        clear_shadow_bank();
        swap_pipelines();
        for (i = 0; i < 6; i++) begin
            run_sample("cleared_shadow", random_sample(), 1'b0);
        end

        // one stall cycle per invalid opcode lets the FIFO fill
        pulses_before = invalid_pulses;
        for (i = 0; i < 2 * fifo_depth; i++) begin
            push_byte(8'hf0 | 8'(i));
        end
        // at most two decode cycles per byte left in the FIFO
        for (i = 0; i < 4 * fifo_depth && fifo_count != '0; i++) begin
            @(negedge clk);
        end
        assert (fifo_count == '0)
        else begin
            $display("fifo_count did not return to 0 after decoding finished");
            value_errors++;
        end
        repeat (4) @(negedge clk);
        // a full FIFO of unknown opcodes was decoded
        assert (invalid_pulses - pulses_before >= fifo_depth)
        else begin
            $display("error unknown_opcode: expected at least %0d, actual %0d",
                     fifo_depth, invalid_pulses - pulses_before);
            value_errors++;
        end

        pulses_before = invalid_pulses;
        set_coef(n_blocks, 4096);
        set_coef(255, 4096);
        assert (invalid_pulses - pulses_before == 2)
        else begin
            $display("error invalid_index: expected 2, actual %0d",
                     invalid_pulses - pulses_before);
            value_errors++;
        end
        // bad writes would have landed in the shadow bank
        swap_pipelines();
        for (i = 0; i < 6; i++) begin
            run_sample("invalid_no_effect", random_sample(), 1'b0);
        end
        assert (max_count > 1)
        else begin
            $display("fifo_count never rose above 1 during the command burst");
            value_errors++;
        end

        for (i = 0; i < 4; i++) begin
            run_sample("busy_strobe", random_sample(), 1'b1);
        end

        repeat (2) @(negedge clk);
        protocol_errors = u_dsp_engine.u_dsp_engine_assert.fail_count;
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
hw/engine_pkg.sv
hw/command_pkg.sv
hw/command_fifo.sv
hw/command_decoder.sv
hw/block_pipeline.sv
hw/pipeline_switch.sv
hw/engine_sequencer.sv
hw/dsp_engine.sv
testbench/dsp_engine_assert.sv
testbench/tb_dsp_engine.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dsp_engine testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_dsp_engine \
    --Mdir obj_dir -o sim_tb_dsp_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_dsp_engine +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
